// ==== common/decode_pkg.sv ====
`default_nettype none

package decode_pkg;

    localparam int xlen       = 32;  // Datapath width
    localparam int reg_addr_w = 5;   // Register index width

    // Major opcodes of the kept RV32I subset
    typedef enum logic [6:0] {
        OPC_BUBBLE = 7'b000_0000,  // All-zero word from the fetch stage
        OPC_LUI    = 7'b011_0111,
        OPC_AUIPC  = 7'b001_0111,
        OPC_JAL    = 7'b110_1111,
        OPC_JALR   = 7'b110_0111,
        OPC_BRANCH = 7'b110_0011,  // BEQ to BGEU
        OPC_LOAD   = 7'b000_0011,  // LB to LHU
        OPC_STORE  = 7'b010_0011,  // SB, SH, SW
        OPC_OP_IMM = 7'b001_0011,  // Register-immediate arithmetic
        OPC_OP     = 7'b011_0011   // Register-register arithmetic
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_NOP  = 4'd0,  // Idle, also used for not-taken branches
        ALU_ADD  = 4'd1,
        ALU_SUB  = 4'd2,
        ALU_SLL  = 4'd3,
        ALU_SLT  = 4'd4,
        ALU_SLTU = 4'd5,
        ALU_XOR  = 4'd6,
        ALU_SRL  = 4'd7,
        ALU_SRA  = 4'd8,
        ALU_OR   = 4'd9,
        ALU_AND  = 4'd10
    } alu_op_e;

    typedef enum logic [1:0] {
        MEM_NOP   = 2'd0,
        MEM_LOAD  = 2'd1,
        MEM_STORE = 2'd2
    } mem_op_e;

    // Access size and extension for loads, size only for stores
    typedef enum logic [2:0] {
        WB_WORD   = 3'd0,
        WB_BYTE_S = 3'd1,
        WB_HALF_S = 3'd2,
        WB_BYTE_U = 3'd3,
        WB_HALF_U = 3'd4
    } wb_type_e;

    typedef enum logic [2:0] {
        IMM_NONE = 3'd0,
        IMM_I    = 3'd1,
        IMM_S    = 3'd2,
        IMM_B    = 3'd3,
        IMM_U    = 3'd4,
        IMM_J    = 3'd5
    } imm_fmt_e;

    typedef enum logic [1:0] {OPA_ZERO, OPA_RS1, OPA_IMM, OPA_PC} opa_sel_e;

    typedef enum logic [2:0] {OPB_ZERO, OPB_RS1, OPB_RS2, OPB_IMM, OPB_PC} opb_sel_e;

    // Control word handed to execute, memory and write-back
    typedef struct packed {
        alu_op_e                alu_op;
        mem_op_e                mem_op;
        logic                   alu_result_sel;  // 1 takes ALU result, 0 takes memory data
        logic                   reg_wb;          // Register file write enable
        wb_type_e               wb_type;
        logic [reg_addr_w-1:0]  rd;              // Destination register
        logic                   jump;            // JAL or JALR
        logic                   branch;          // Conditional branch
        logic                   store;           // Store needs rs2 data downstream
    } ctrl_t;

    // One result still in flight in a younger stage
    typedef struct packed {
        logic [reg_addr_w-1:0]  rd;
        logic [xlen-1:0]        data;
    } fwd_stage_t;

endpackage

`default_nettype wire

// ==== verilog/decode_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_control (
    input  logic [decode_pkg::xlen-1:0]       instruction,
    output decode_pkg::ctrl_t                 ctrl,
    output decode_pkg::imm_fmt_e              imm_fmt,
    output decode_pkg::opa_sel_e              opa_sel,
    output decode_pkg::opb_sel_e              opb_sel,
    output logic [decode_pkg::reg_addr_w-1:0] rs1_addr,
    output logic [decode_pkg::reg_addr_w-1:0] rs2_addr
);

    logic [2:0] funct3;  // Minor opcode
    logic       alt;     // Bit 30 picks SUB and SRA

    assign funct3 = instruction[14:12];
    assign alt    = instruction[30];

    // Shared arithmetic decode, OP-IMM never subtracts
    function automatic decode_pkg::alu_op_e arith_op(input logic [2:0] f3,
                                                     input logic       sub_en,
                                                     input logic       sra_en);
        case (f3)
            3'b000:  arith_op = sub_en ? decode_pkg::ALU_SUB : decode_pkg::ALU_ADD;
            3'b001:  arith_op = decode_pkg::ALU_SLL;
            3'b010:  arith_op = decode_pkg::ALU_SLT;
            3'b011:  arith_op = decode_pkg::ALU_SLTU;
            3'b100:  arith_op = decode_pkg::ALU_XOR;
            3'b101:  arith_op = sra_en ? decode_pkg::ALU_SRA : decode_pkg::ALU_SRL;
            3'b110:  arith_op = decode_pkg::ALU_OR;
            default: arith_op = decode_pkg::ALU_AND;
        endcase
    endfunction

    always_comb begin
        ctrl     = '0;                       // Bubble, unknown, FENCE and SYSTEM stay all zero
        imm_fmt  = decode_pkg::IMM_NONE;
        opa_sel  = decode_pkg::OPA_ZERO;
        opb_sel  = decode_pkg::OPB_ZERO;
        rs1_addr = '0;
        rs2_addr = '0;
        case (decode_pkg::opcode_e'(instruction[6:0]))
            decode_pkg::OPC_LUI, decode_pkg::OPC_AUIPC: begin
                ctrl.alu_op         = decode_pkg::ALU_ADD;
                ctrl.alu_result_sel = 1'b1;
                ctrl.reg_wb         = 1'b1;
                ctrl.rd             = instruction[11:7];
                imm_fmt             = decode_pkg::IMM_U;
                opa_sel             = decode_pkg::OPA_IMM;
                opb_sel             = instruction[5] ? decode_pkg::OPB_ZERO  // LUI adds zero
                                                     : decode_pkg::OPB_PC;   // AUIPC adds pc
            end
            decode_pkg::OPC_JAL, decode_pkg::OPC_JALR: begin
                ctrl.alu_op         = decode_pkg::ALU_ADD;  // ALU forms the target
                ctrl.alu_result_sel = 1'b1;
                ctrl.reg_wb         = 1'b1;
                ctrl.rd             = instruction[11:7];
                ctrl.jump           = 1'b1;
                opa_sel             = decode_pkg::OPA_IMM;
                if (instruction[3]) begin                   // JAL
                    imm_fmt = decode_pkg::IMM_J;
                    opb_sel = decode_pkg::OPB_PC;
                end else begin                              // JALR
                    imm_fmt  = decode_pkg::IMM_I;
                    opb_sel  = decode_pkg::OPB_RS1;
                    rs1_addr = instruction[19:15];
                end
            end
            decode_pkg::OPC_BRANCH: begin
                ctrl.alu_op         = decode_pkg::ALU_ADD;  // Dropped later if not taken
                ctrl.alu_result_sel = 1'b1;
                ctrl.branch         = 1'b1;
                imm_fmt             = decode_pkg::IMM_B;
                opa_sel             = decode_pkg::OPA_PC;
                opb_sel             = decode_pkg::OPB_IMM;
                rs1_addr            = instruction[19:15];
                rs2_addr            = instruction[24:20];
            end
            decode_pkg::OPC_LOAD: begin
                ctrl.alu_op = decode_pkg::ALU_ADD;          // Address is rs1 plus offset
                ctrl.mem_op = decode_pkg::MEM_LOAD;
                ctrl.reg_wb = 1'b1;                         // Result comes from memory
                ctrl.rd     = instruction[11:7];
                case (funct3)
                    3'b000:  ctrl.wb_type = decode_pkg::WB_BYTE_S;
                    3'b001:  ctrl.wb_type = decode_pkg::WB_HALF_S;
                    3'b100:  ctrl.wb_type = decode_pkg::WB_BYTE_U;
                    3'b101:  ctrl.wb_type = decode_pkg::WB_HALF_U;
                    default: ctrl.wb_type = decode_pkg::WB_WORD;
                endcase
                imm_fmt  = decode_pkg::IMM_I;
                opa_sel  = decode_pkg::OPA_RS1;
                opb_sel  = decode_pkg::OPB_IMM;
                rs1_addr = instruction[19:15];
            end
            decode_pkg::OPC_STORE: begin
                ctrl.alu_op = decode_pkg::ALU_ADD;
                ctrl.mem_op = decode_pkg::MEM_STORE;
                ctrl.store  = 1'b1;
                case (funct3)
                    3'b000:  ctrl.wb_type = decode_pkg::WB_BYTE_S;  // Size of the write
                    3'b001:  ctrl.wb_type = decode_pkg::WB_HALF_S;
                    default: ctrl.wb_type = decode_pkg::WB_WORD;
                endcase
                imm_fmt  = decode_pkg::IMM_S;
                opa_sel  = decode_pkg::OPA_RS1;
                opb_sel  = decode_pkg::OPB_IMM;
                rs1_addr = instruction[19:15];
                rs2_addr = instruction[24:20];              // Store data source
            end
            decode_pkg::OPC_OP_IMM, decode_pkg::OPC_OP: begin
                ctrl.alu_result_sel = 1'b1;
                ctrl.reg_wb         = 1'b1;
                ctrl.rd             = instruction[11:7];
                opa_sel             = decode_pkg::OPA_RS1;
                rs1_addr            = instruction[19:15];
                if (instruction[5]) begin                   // OP, register operand
                    ctrl.alu_op = arith_op(funct3, alt, alt);
                    opb_sel     = decode_pkg::OPB_RS2;
                    rs2_addr    = instruction[24:20];
                end else begin                              // OP-IMM, bit 30 is immediate
                    ctrl.alu_op = arith_op(funct3, 1'b0, alt);
                    imm_fmt     = decode_pkg::IMM_I;
                    opb_sel     = decode_pkg::OPB_IMM;
                end
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/imm_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module imm_gen (
    input  logic [decode_pkg::xlen-1:0] instruction,
    input  decode_pkg::imm_fmt_e        imm_fmt,
    output logic [decode_pkg::xlen-1:0] imm
);

    logic sign;  // Every format extends from bit 31

    assign sign = instruction[31];

    always_comb begin
        case (imm_fmt)
            decode_pkg::IMM_I: begin
                imm = {{20{sign}}, instruction[31:20]};
            end
            decode_pkg::IMM_S: begin
                imm = {{20{sign}}, instruction[31:25], instruction[11:7]};
            end
            decode_pkg::IMM_B: begin
                imm = {{19{sign}}, sign, instruction[7], instruction[30:25],
                       instruction[11:8], 1'b0};  // Halfword aligned offset
            end
            decode_pkg::IMM_U: begin
                imm = {instruction[31:12], 12'd0};  // Upper 20 bits, low bits clear
            end
            decode_pkg::IMM_J: begin
                imm = {{11{sign}}, sign, instruction[19:12], instruction[20],
                       instruction[30:21], 1'b0};
            end
            default: begin
                imm = '0;  // No immediate in this format
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/operand_forward.sv ====
`timescale 1ns/1ps
`default_nettype none

module operand_forward (
    input  logic [decode_pkg::reg_addr_w-1:0] rs1_addr,
    input  logic [decode_pkg::reg_addr_w-1:0] rs2_addr,
    input  logic [decode_pkg::xlen-1:0]       rs1_data,
    input  logic [decode_pkg::xlen-1:0]       rs2_data,
    input  decode_pkg::fwd_stage_t            fwd_1c,    // Producer one instruction older
    input  decode_pkg::fwd_stage_t            fwd_2c,
    input  decode_pkg::fwd_stage_t            fwd_3c,    // Oldest in-flight result
    output logic [decode_pkg::xlen-1:0]       rs1_val,
    output logic [decode_pkg::xlen-1:0]       rs2_val
);

    // Youngest matching producer wins, x0 always reads the register file
    function automatic logic [decode_pkg::xlen-1:0] pick(
        input logic [decode_pkg::reg_addr_w-1:0] addr,
        input logic [decode_pkg::xlen-1:0]       rf_data,
        input decode_pkg::fwd_stage_t            s1,
        input decode_pkg::fwd_stage_t            s2,
        input decode_pkg::fwd_stage_t            s3
    );
        if (addr == '0) begin
            pick = rf_data;
        end else if (addr == s1.rd) begin
            pick = s1.data;
        end else if (addr == s2.rd) begin
            pick = s2.data;
        end else if (addr == s3.rd) begin
            pick = s3.data;
        end else begin
            pick = rf_data;  // Nothing in flight for this register
        end
    endfunction

    always_comb begin
        rs1_val = pick(rs1_addr, rs1_data, fwd_1c, fwd_2c, fwd_3c);  // Sources resolve independently
        rs2_val = pick(rs2_addr, rs2_data, fwd_1c, fwd_2c, fwd_3c);
    end

endmodule

`default_nettype wire

// ==== verilog/branch_compare.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_compare (
    input  logic [2:0]                  funct3,
    input  logic [decode_pkg::xlen-1:0] rs1_val,
    input  logic [decode_pkg::xlen-1:0] rs2_val,
    output logic                        cond_met
);

    logic equal;    // Shared by BEQ and BNE
    logic lt_s;     // Signed less than
    logic lt_u;     // Unsigned less than

    assign equal = (rs1_val == rs2_val);
    assign lt_s  = ($signed(rs1_val) < $signed(rs2_val));
    assign lt_u  = (rs1_val < rs2_val);

    always_comb begin
        case (funct3)
            3'b000:  cond_met = equal;   // BEQ
            3'b001:  cond_met = !equal;  // BNE
            3'b100:  cond_met = lt_s;    // BLT
            3'b101:  cond_met = !lt_s;   // BGE
            3'b110:  cond_met = lt_u;    // BLTU
            3'b111:  cond_met = !lt_u;   // BGEU
            default: cond_met = 1'b0;    // Codes 2 and 3 are reserved
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/issue_register.sv ====
`timescale 1ns/1ps
`default_nettype none

module issue_register (
    input  logic                        clk,
    input  logic                        rst_n,
    input  decode_pkg::ctrl_t           ctrl,
    input  decode_pkg::opa_sel_e        opa_sel,
    input  decode_pkg::opb_sel_e        opb_sel,
    input  logic [decode_pkg::xlen-1:0] imm,
    input  logic [decode_pkg::xlen-1:0] pc,
    input  logic [decode_pkg::xlen-1:0] rs1_val,
    input  logic [decode_pkg::xlen-1:0] rs2_val,
    input  logic                        cond_met,
    output logic [decode_pkg::xlen-1:0] alu_a,
    output logic [decode_pkg::xlen-1:0] alu_b,
    output decode_pkg::ctrl_t           ctrl_q,
    output logic                        update_pc,
    output logic [decode_pkg::xlen-1:0] store_data
);

    logic [decode_pkg::xlen-1:0] alu_a_d;
    logic [decode_pkg::xlen-1:0] alu_b_d;
    decode_pkg::ctrl_t           ctrl_d;
    logic                        taken;   // Jump or branch that redirects fetch

    assign taken = ctrl.jump | (ctrl.branch & cond_met);

    always_comb begin
        case (opa_sel)
            decode_pkg::OPA_RS1: alu_a_d = rs1_val;
            decode_pkg::OPA_IMM: alu_a_d = imm;
            decode_pkg::OPA_PC:  alu_a_d = pc;
            default:             alu_a_d = '0;
        endcase
        case (opb_sel)
            decode_pkg::OPB_RS1: alu_b_d = rs1_val;  // JALR base
            decode_pkg::OPB_RS2: alu_b_d = rs2_val;
            decode_pkg::OPB_IMM: alu_b_d = imm;
            decode_pkg::OPB_PC:  alu_b_d = pc;
            default:             alu_b_d = '0;
        endcase
        ctrl_d = ctrl;
        if (ctrl.branch && !cond_met) begin
            ctrl_d.alu_op = decode_pkg::ALU_NOP;     // Not-taken branch does no ALU work
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            alu_a      <= '0;
            alu_b      <= '0;
            ctrl_q     <= '0;                        // NOP, no write-back, WORD
            update_pc  <= 1'b0;
            store_data <= '0;
        end else begin
            alu_a      <= alu_a_d;
            alu_b      <= alu_b_d;
            ctrl_q     <= ctrl_d;
            update_pc  <= taken;
            store_data <= ctrl.store ? rs2_val : '0; // Forwarded rs2 for stores only
        end
    end

endmodule

`default_nettype wire

// ==== verilog/instruction_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module instruction_decode (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [decode_pkg::xlen-1:0]       instruction,
    input  logic [decode_pkg::xlen-1:0]       pc,
    input  logic [decode_pkg::xlen-1:0]       rs1_data,     // Register file, same cycle
    input  logic [decode_pkg::xlen-1:0]       rs2_data,
    input  decode_pkg::fwd_stage_t            fwd_1c,
    input  decode_pkg::fwd_stage_t            fwd_2c,
    input  decode_pkg::fwd_stage_t            fwd_3c,
    output logic [decode_pkg::reg_addr_w-1:0] rs1_addr,     // Unregistered, to register file
    output logic [decode_pkg::reg_addr_w-1:0] rs2_addr,
    output logic [decode_pkg::xlen-1:0]       alu_a,
    output logic [decode_pkg::xlen-1:0]       alu_b,
    output decode_pkg::ctrl_t                 ctrl_q,
    output logic                              update_pc,
    output logic [decode_pkg::xlen-1:0]       store_data
);

    decode_pkg::ctrl_t           ctrl;
    decode_pkg::imm_fmt_e        imm_fmt;
    decode_pkg::opa_sel_e        opa_sel;
    decode_pkg::opb_sel_e        opb_sel;
    logic [decode_pkg::xlen-1:0] imm;
    logic [decode_pkg::xlen-1:0] rs1_val;    // After forwarding
    logic [decode_pkg::xlen-1:0] rs2_val;
    logic                        cond_met;

    decode_control i_decode_control (
        .instruction (instruction), .ctrl (ctrl), .imm_fmt (imm_fmt),
        .opa_sel (opa_sel), .opb_sel (opb_sel),
        .rs1_addr (rs1_addr), .rs2_addr (rs2_addr)
    );

    imm_gen i_imm_gen (.instruction (instruction), .imm_fmt (imm_fmt), .imm (imm));

    operand_forward i_operand_forward (
        .rs1_addr (rs1_addr), .rs2_addr (rs2_addr),
        .rs1_data (rs1_data), .rs2_data (rs2_data),
        .fwd_1c (fwd_1c), .fwd_2c (fwd_2c), .fwd_3c (fwd_3c),
        .rs1_val (rs1_val), .rs2_val (rs2_val)
    );

    branch_compare i_branch_compare (
        .funct3 (instruction[14:12]), .rs1_val (rs1_val), .rs2_val (rs2_val),
        .cond_met (cond_met)
    );

    issue_register i_issue_register (
        .clk (clk), .rst_n (rst_n), .ctrl (ctrl), .opa_sel (opa_sel), .opb_sel (opb_sel),
        .imm (imm), .pc (pc), .rs1_val (rs1_val), .rs2_val (rs2_val), .cond_met (cond_met),
        .alu_a (alu_a), .alu_b (alu_b), .ctrl_q (ctrl_q), .update_pc (update_pc),
        .store_data (store_data)
    );

endmodule

`default_nettype wire

// ==== verification/tb_instruction_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_instruction_decode;

    localparam int clk_period      = 10;  // ns
    localparam int reset_cycles    = 16;
    localparam int num_instr       = 2000;
    localparam int watchdog_cycles = num_instr + reset_cycles + 20;

    logic                        clk;
    logic                        rst_n;
    logic [31:0]                 instruction;
    logic [31:0]                 pc;
    logic [31:0]                 rs1_data;
    logic [31:0]                 rs2_data;
    decode_pkg::fwd_stage_t      fwd_1c;
    decode_pkg::fwd_stage_t      fwd_2c;
    decode_pkg::fwd_stage_t      fwd_3c;
    logic [4:0]                  rs1_addr;
    logic [4:0]                  rs2_addr;
    logic [31:0]                 alu_a;
    logic [31:0]                 alu_b;
    decode_pkg::ctrl_t           ctrl_q;
    logic                        update_pc;
    logic [31:0]                 store_data;

    logic [31:0]                 lfsr_state;   // Galois LFSR, seed 4
    int                          errors;
    int                          checks;

    string                       exp_test;     // Expectations for the instruction in flight
    logic [4:0]                  exp_rs1_addr;
    logic [4:0]                  exp_rs2_addr;
    logic [31:0]                 exp_alu_a;
    logic [31:0]                 exp_alu_b;
    decode_pkg::ctrl_t           exp_ctrl;
    logic                        exp_update_pc;
    logic [31:0]                 exp_store_data;

    instruction_decode i_dut (
        .clk (clk), .rst_n (rst_n), .instruction (instruction), .pc (pc),
        .rs1_data (rs1_data), .rs2_data (rs2_data),
        .fwd_1c (fwd_1c), .fwd_2c (fwd_2c), .fwd_3c (fwd_3c),
        .rs1_addr (rs1_addr), .rs2_addr (rs2_addr), .alu_a (alu_a), .alu_b (alu_b),
        .ctrl_q (ctrl_q), .update_pc (update_pc), .store_data (store_data)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        lfsr_step = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);  // x^32+x^22+x^2+x+1
    endfunction

    // One LFSR step per bit, bits shifted in from the right
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] imm_i(input logic [31:0] w);
        imm_i = {{20{w[31]}}, w[31:20]};
    endfunction

    function automatic logic [31:0] imm_s(input logic [31:0] w);
        imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
    endfunction

    function automatic logic [31:0] imm_b(input logic [31:0] w);
        imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    endfunction

    function automatic logic [31:0] imm_u(input logic [31:0] w);
        imm_u = {w[31:12], 12'h000};
    endfunction

    function automatic logic [31:0] imm_j(input logic [31:0] w);
        imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    endfunction

    // Oldest stage first, each younger match overrides
    function automatic logic [31:0] fwd_value(input logic [4:0] addr, input logic [31:0] rf);
        logic [31:0] v;
        v = rf;
        if (addr != 5'd0) begin
            if (fwd_3c.rd == addr) v = fwd_3c.data;
            if (fwd_2c.rd == addr) v = fwd_2c.data;
            if (fwd_1c.rd == addr) v = fwd_1c.data;
        end
        return v;
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                          input logic [31:0] b);
        case (f3)
            3'd0:    branch_taken = (a == b);
            3'd1:    branch_taken = (a != b);
            3'd4:    branch_taken = ($signed(a) < $signed(b));
            3'd5:    branch_taken = ($signed(a) >= $signed(b));
            3'd6:    branch_taken = (a < b);
            3'd7:    branch_taken = (a >= b);
            default: branch_taken = 1'b0;  // Reserved codes
        endcase
    endfunction

    function automatic decode_pkg::alu_op_e arith_alu_op(input logic [2:0] f3,
                                                         input logic is_op, input logic b30);
        case (f3)
            3'd0:    arith_alu_op = (is_op && b30) ? decode_pkg::ALU_SUB : decode_pkg::ALU_ADD;
            3'd1:    arith_alu_op = decode_pkg::ALU_SLL;
            3'd2:    arith_alu_op = decode_pkg::ALU_SLT;
            3'd3:    arith_alu_op = decode_pkg::ALU_SLTU;
            3'd4:    arith_alu_op = decode_pkg::ALU_XOR;
            3'd5:    arith_alu_op = b30 ? decode_pkg::ALU_SRA : decode_pkg::ALU_SRL;
            3'd6:    arith_alu_op = decode_pkg::ALU_OR;
            default: arith_alu_op = decode_pkg::ALU_AND;
        endcase
    endfunction

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] got);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Mismatch %s: expected %h, actual %h", name, exp, got);
        end
    endtask

    // Random instruction plus register file and in-flight data, small register indices
    task automatic drive_random();
        logic [3:0]  kind;
        logic [31:0] w;
        logic [2:0]  f3;
        kind     = 4'(rand_bits(4));
        w        = rand_bits(32);
        w[11:7]  = 5'(rand_bits(3));
        w[19:15] = 5'(rand_bits(3));
        w[24:20] = 5'(rand_bits(3));
        case (kind)
            4'd0:        w[6:0] = 7'b0110111;                    // LUI
            4'd1:        w[6:0] = 7'b0010111;                    // AUIPC
            4'd2:        w[6:0] = 7'b1101111;                    // JAL
            4'd3:        w[6:0] = 7'b1100111;                    // JALR
            4'd4, 4'd5:  w[6:0] = 7'b1100011;                    // Branch, all funct3
            4'd6, 4'd12: begin
                f3 = 3'(rand_bits(3));
                if (f3 == 3'd3 || f3 >= 3'd6) f3 = 3'd2;         // Keep to LB..LHU
                w[14:12] = f3;
                w[6:0]   = 7'b0000011;
            end
            4'd7, 4'd15: begin
                f3 = 3'(rand_bits(2));
                if (f3 == 3'd3) f3 = 3'd2;                       // SB, SH, SW
                w[14:12] = f3;
                w[6:0]   = 7'b0100011;
            end
            4'd8, 4'd9:  w[6:0] = 7'b0010011;                    // OP-IMM
            4'd10, 4'd11: begin
                w[31:25] = {1'b0, rand_bits(1) != 0, 5'b00000};  // funct7 0 or 0x20
                w[6:0]   = 7'b0110011;
            end
            4'd13:       w = '0;                                 // Bubble
            default: begin
                case (rand_bits(2))
                    32'd0:   w[6:0] = 7'b0001111;                // FENCE
                    32'd1:   w[6:0] = 7'b1110011;                // SYSTEM
                    32'd2:   w[6:0] = 7'b0001011;
                    default: w[6:0] = 7'b0101011;
                endcase
            end
        endcase
        instruction = w;
        pc          = rand_bits(30) << 2;
        rs1_data    = rand_bits(32);
        rs2_data    = (rand_bits(2) == 0) ? rs1_data : rand_bits(32);  // Equal values for BEQ
        fwd_1c.rd   = 5'(rand_bits(3));
        fwd_1c.data = rand_bits(32);
        fwd_2c.rd   = 5'(rand_bits(3));
        fwd_2c.data = rand_bits(32);
        fwd_3c.rd   = 5'(rand_bits(3));
        fwd_3c.data = rand_bits(32);
    endtask

    // Reference model for the instruction now on the inputs
    task automatic predict();
        logic [31:0] w;
        logic [31:0] v1;
        logic [31:0] v2;
        logic        taken;
        w              = instruction;
        exp_ctrl       = '0;
        exp_rs1_addr   = '0;
        exp_rs2_addr   = '0;
        exp_alu_a      = '0;
        exp_alu_b      = '0;
        exp_update_pc  = 1'b0;
        exp_store_data = '0;
        exp_test       = (w == 32'd0) ? "bubble" : "unknown";
        case (w[6:0])
            7'b0110111, 7'b0010111, 7'b1101111, 7'b1100111, 7'b0010011, 7'b0110011: begin
                exp_ctrl.alu_op         = decode_pkg::ALU_ADD;
                exp_ctrl.alu_result_sel = 1'b1;
                exp_ctrl.reg_wb         = 1'b1;
                exp_ctrl.rd             = w[11:7];
            end
            default: begin
            end
        endcase
        case (w[6:0])
            7'b1100011, 7'b0100011, 7'b0110011: begin              // Two source registers
                exp_rs1_addr = w[19:15];
                exp_rs2_addr = w[24:20];
            end
            7'b1100111, 7'b0000011, 7'b0010011: begin
                exp_rs1_addr = w[19:15];
            end
            default: begin
            end
        endcase
        v1 = fwd_value(exp_rs1_addr, rs1_data);
        v2 = fwd_value(exp_rs2_addr, rs2_data);
        case (w[6:0])
            7'b0110111: begin
                exp_test  = "lui";
                exp_alu_a = imm_u(w);
            end
            7'b0010111: begin
                exp_test  = "auipc";
                exp_alu_a = imm_u(w);
                exp_alu_b = pc;
            end
            7'b1101111: begin
                exp_test      = "jal";
                exp_ctrl.jump = 1'b1;
                exp_alu_a     = imm_j(w);
                exp_alu_b     = pc;
                exp_update_pc = 1'b1;
            end
            7'b1100111: begin
                exp_test      = "jalr";
                exp_ctrl.jump = 1'b1;
                exp_alu_a     = imm_i(w);
                exp_alu_b     = v1;
                exp_update_pc = 1'b1;
            end
            7'b1100011: begin
                exp_test                = "branch";
                taken                   = branch_taken(w[14:12], v1, v2);
                exp_ctrl.alu_op         = taken ? decode_pkg::ALU_ADD : decode_pkg::ALU_NOP;
                exp_ctrl.alu_result_sel = 1'b1;
                exp_ctrl.branch         = 1'b1;
                exp_alu_a               = pc;
                exp_alu_b               = imm_b(w);
                exp_update_pc           = taken;
            end
            7'b0000011: begin
                exp_test        = "load";
                exp_ctrl.alu_op = decode_pkg::ALU_ADD;
                exp_ctrl.mem_op = decode_pkg::MEM_LOAD;
                exp_ctrl.reg_wb = 1'b1;                           // Data from memory
                exp_ctrl.rd     = w[11:7];
                case (w[14:12])
                    3'd0:    exp_ctrl.wb_type = decode_pkg::WB_BYTE_S;
                    3'd1:    exp_ctrl.wb_type = decode_pkg::WB_HALF_S;
                    3'd4:    exp_ctrl.wb_type = decode_pkg::WB_BYTE_U;
                    3'd5:    exp_ctrl.wb_type = decode_pkg::WB_HALF_U;
                    default: exp_ctrl.wb_type = decode_pkg::WB_WORD;
                endcase
                exp_alu_a = v1;
                exp_alu_b = imm_i(w);
            end
            7'b0100011: begin
                exp_test         = "store";
                exp_ctrl.alu_op  = decode_pkg::ALU_ADD;
                exp_ctrl.mem_op  = decode_pkg::MEM_STORE;
                exp_ctrl.store   = 1'b1;
                exp_ctrl.wb_type = (w[14:12] == 3'd0) ? decode_pkg::WB_BYTE_S :
                                   (w[14:12] == 3'd1) ? decode_pkg::WB_HALF_S :
                                                        decode_pkg::WB_WORD;
                exp_alu_a        = v1;
                exp_alu_b        = imm_s(w);
                exp_store_data   = v2;
            end
            7'b0010011: begin
                exp_test        = "op_imm";
                exp_ctrl.alu_op = arith_alu_op(w[14:12], 1'b0, w[30]);
                exp_alu_a       = v1;
                exp_alu_b       = imm_i(w);
            end
            7'b0110011: begin
                exp_test        = "op";
                exp_ctrl.alu_op = arith_alu_op(w[14:12], 1'b1, w[30]);
                exp_alu_a       = v1;
                exp_alu_b       = v2;
            end
            default: begin
            end
        endcase
    endtask

    // Address outputs still reflect the current inputs, registers hold the last capture
    task automatic check_outputs();
        check_word($sformatf("%s.rs1_addr", exp_test), exp_rs1_addr, rs1_addr);
        check_word($sformatf("%s.rs2_addr", exp_test), exp_rs2_addr, rs2_addr);
        check_word($sformatf("%s.alu_a", exp_test), exp_alu_a, alu_a);
        check_word($sformatf("%s.alu_b", exp_test), exp_alu_b, alu_b);
        check_word($sformatf("%s.ctrl_q", exp_test), exp_ctrl, ctrl_q);
        check_word($sformatf("%s.update_pc", exp_test), exp_update_pc, update_pc);
        check_word($sformatf("%s.store_data", exp_test), exp_store_data, store_data);
    endtask

    initial begin
        instruction = '0;
        pc          = '0;
        rs1_data    = '0;
        rs2_data    = '0;
        fwd_1c      = '0;
        fwd_2c      = '0;
        fwd_3c      = '0;
        rst_n       = 1'b0;
        lfsr_state  = 32'd4;
        errors      = 0;
        checks      = 0;
        repeat (reset_cycles) @(negedge clk);
        rst_n = 1'b1;
        check_word("reset.alu_a", 32'd0, alu_a);
        check_word("reset.alu_b", 32'd0, alu_b);
        check_word("reset.ctrl_q", 32'd0, ctrl_q);                     // NOP, NOP, WORD
        check_word("reset.update_pc", 32'd0, update_pc);
        check_word("reset.store_data", 32'd0, store_data);
        for (int n = 0; n < num_instr; n++) begin
            drive_random();
            predict();
            @(negedge clk);
            check_outputs();
        end
        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        #(watchdog_cycles * clk_period);
        errors++;
        $display("Timeout: the run did not end within %0d cycles", watchdog_cycles);
        $display("Checks %0d, errors %0d", checks, errors);
        $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
common/decode_pkg.sv
verilog/decode_control.sv
verilog/imm_gen.sv
verilog/operand_forward.sv
verilog/branch_compare.sv
verilog/issue_register.sv
verilog/instruction_decode.sv
verification/tb_instruction_decode.sv

// ==== Bender.yml ====
package:
  name: instruction_decode

sources:
  - common/decode_pkg.sv
  - verilog/decode_control.sv
  - verilog/imm_gen.sv
  - verilog/operand_forward.sv
  - verilog/branch_compare.sv
  - verilog/issue_register.sv
  - verilog/instruction_decode.sv
  - target: test
    files:
      - verification/tb_instruction_decode.sv
